/* hdl/mmio_pkg.sv */
package mmio_pkg;

    // Masters on the shared register bus.
    // Master 0 is the core data port and master 1 is the debug port.
    localparam int N_MASTERS = 2;

    // One master access.
    // The strobe stays high with address and data stable until the grant.
    typedef struct packed {
        logic [31:0] addr;   // Absolute byte address.
        logic [31:0] wdata;  // Write data.
        logic        we;     // High for a write.
        logic        req;    // Request strobe.
    } bus_req_t;

    // Read response.
    // Valid pulses for one cycle, one cycle after the grant.
    typedef struct packed {
        logic [31:0] rdata;  // Read data.
        logic        valid;  // One-cycle strobe.
    } bus_rsp_t;

    // Byte offsets from the block base address.
    localparam logic [31:0] REG_UART_STATUS = 32'h0000_0000;  // Read. TX ready, RX valid.
    localparam logic [31:0] REG_UART_RX     = 32'h0000_0004;  // Read. Pops the held byte.
    localparam logic [31:0] REG_UART_TX     = 32'h0000_0008;  // Write. Low byte is sent.
    localparam logic [31:0] REG_CYCLES      = 32'h0000_0010;  // Read. Clocks since clear.
    localparam logic [31:0] REG_INSTRET     = 32'h0000_0014;  // Read. Retired instructions.
    localparam logic [31:0] REG_CLEAR       = 32'h0000_0018;  // Write. Zeroes two counters.
    localparam logic [31:0] REG_BRANCHES    = 32'h0000_001C;  // Read. Branches seen.
    localparam logic [31:0] REG_BR_HITS     = 32'h0000_0020;  // Read. Correct predictions.

    // Bit positions in the UART status word.
    localparam int STAT_TX_READY = 0;  // Transmitter can take a byte.
    localparam int STAT_RX_VALID = 1;  // Receiver holds an unread byte.

endpackage

/* hdl/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  mmio_pkg::bus_req_t [mmio_pkg::N_MASTERS-1:0] req_in,
    output logic               [mmio_pkg::N_MASTERS-1:0] gnt,
    output mmio_pkg::bus_req_t                           sel_req,
    input  mmio_pkg::bus_rsp_t                           sel_rsp,
    output mmio_pkg::bus_rsp_t [mmio_pkg::N_MASTERS-1:0] rsp_out
);

    logic prio;     // Master that wins a tie.
    logic win_idx;  // Master granted this cycle.
    logic owner;    // Master granted last time.

    // Grant is combinational so an idle bus costs no cycle.
    always_comb begin
        gnt = '0;
        if (req_in[prio].req) begin
            gnt[prio] = 1'b1;
        end else if (req_in[~prio].req) begin
            gnt[~prio] = 1'b1;  // Other master only when the favoured one is idle.
        end
    end

    assign win_idx = gnt[1];

    // Forward the winner. Strobe only when someone is granted.
    always_comb begin
        sel_req     = req_in[win_idx];
        sel_req.req = |gnt;
    end

    // Priority flips to the loser after every grant.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio  <= 1'b0;
            owner <= 1'b0;
        end else if (|gnt) begin
            prio  <= ~win_idx;
            owner <= win_idx;  // Response of the next cycle goes here.
        end
    end

    // Data fans out to all masters. Valid reaches the owner only.
    always_comb begin
        for (int i = 0; i < mmio_pkg::N_MASTERS; i++) begin
            rsp_out[i].rdata = sel_rsp.rdata;
            rsp_out[i].valid = sel_rsp.valid && (owner == 1'(i));
        end
    end

    // At most one master owns the bus in a cycle.
    a_gnt_onehot : assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(gnt)
    ) else $error("bus_arbiter: more than one grant");

    // A response only ever follows a grant by one cycle.
    a_rsp_after_gnt : assert property (
        @(posedge clk) disable iff (!rst_n) sel_rsp.valid |-> $past(|gnt)
    ) else $error("bus_arbiter: response without a grant");

endmodule

/* hdl/io_regs.sv */
`timescale 1ns/1ps

module io_regs #(
    parameter logic [31:0] MMIO_BASE = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mmio_pkg::bus_req_t req,
    output mmio_pkg::bus_rsp_t rsp,
    input  logic               inst_retired,
    input  logic               br_inst,
    input  logic               br_pred,
    output logic               tx_load,
    output logic [7:0]         tx_byte,
    input  logic               tx_busy,
    output logic               rx_pop,
    input  logic [7:0]         rx_byte,
    input  logic               rx_valid
);

    logic [31:0] offset;       // Address relative to the base.
    logic        rd;           // Granted read.
    logic        wr;           // Granted write.
    logic        clear;        // Counter clear write.
    logic        tx_wr;        // Write to the TX register.
    logic        rx_rd;        // Read of the RX register.
    logic [31:0] status;
    logic [31:0] rd_word;      // Read mux output.
    logic [31:0] cycle_ctr;
    logic [31:0] inst_ctr;
    logic [31:0] br_inst_ctr;
    logic [31:0] br_pred_ctr;
    logic        rsp_valid;
    logic [31:0] rsp_data;

    // Addresses below the base wrap to large offsets and miss the map.
    assign offset = req.addr - MMIO_BASE;
    assign rd     = req.req & ~req.we;
    assign wr     = req.req & req.we;
    assign clear  = wr && (offset == mmio_pkg::REG_CLEAR);
    assign tx_wr  = wr && (offset == mmio_pkg::REG_UART_TX);
    assign rx_rd  = rd && (offset == mmio_pkg::REG_UART_RX);

    always_comb begin
        status = '0;
        status[mmio_pkg::STAT_TX_READY] = ~tx_busy;
        status[mmio_pkg::STAT_RX_VALID] = rx_valid;
    end

    // Write-only and unmapped offsets read as zero.
    always_comb begin
        case (offset)
            mmio_pkg::REG_UART_STATUS: rd_word = status;
            mmio_pkg::REG_UART_RX:     rd_word = {24'h0, rx_byte};
            mmio_pkg::REG_CYCLES:      rd_word = cycle_ctr;   // Count at the grant cycle.
            mmio_pkg::REG_INSTRET:     rd_word = inst_ctr;
            mmio_pkg::REG_BRANCHES:    rd_word = br_inst_ctr;
            mmio_pkg::REG_BR_HITS:     rd_word = br_pred_ctr;
            default:                   rd_word = '0;
        endcase
    end

    // Performance counters.
    // Clear hits cycles and instructions only.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_ctr   <= '0;
            inst_ctr    <= '0;
            br_inst_ctr <= '0;
            br_pred_ctr <= '0;
        end else begin
            if (clear) begin
                cycle_ctr <= '0;
                inst_ctr  <= '0;  // Wins over a retire in the same cycle.
            end else begin
                cycle_ctr <= cycle_ctr + 32'd1;
                if (inst_retired) inst_ctr <= inst_ctr + 32'd1;
            end
            if (br_inst) br_inst_ctr <= br_inst_ctr + 32'd1;
            if (br_pred) br_pred_ctr <= br_pred_ctr + 32'd1;
        end
    end

    // Response and UART strobes, one cycle after the grant.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rx_pop    <= 1'b0;
            tx_load   <= 1'b0;
        end else begin
            rsp_valid <= rd;                // Writes give no response.
            rx_pop    <= rx_rd && rx_valid; // Nothing to pop when empty.
            tx_load   <= tx_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) rsp_data <= rd_word;
        if (tx_wr) tx_byte <= req.wdata[7:0];
    end

    assign rsp.rdata = rsp_data;
    assign rsp.valid = rsp_valid;

    // Pop only a byte that the receiver still holds.
    a_pop_valid : assert property (
        @(posedge clk) disable iff (!rst_n) rx_pop |-> rx_valid
    ) else $error("io_regs: rx_pop with no byte held");

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_load,
    input  logic [7:0] tx_byte,
    output logic       tx_busy,
    output logic       tx_line
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic [CNT_W-1:0] clk_cnt;  // Clocks into the current bit.
    logic [3:0]       bit_idx;  // 0 start, 1..8 data, 9 stop.
    logic [8:0]       shift;    // Data bits then the stop bit.
    logic             load;     // Accepted load.
    logic             bit_end;  // Last clock of a bit period.

    assign load    = tx_load && !tx_busy;  // Load while busy is dropped.
    assign bit_end = tx_busy && (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            tx_line <= 1'b1;  // Idle line is high.
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (load) begin
            tx_busy <= 1'b1;
            tx_line <= 1'b0;  // Start bit on the next cycle.
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (bit_end) begin
            clk_cnt <= '0;
            if (bit_idx == 4'd9) begin
                tx_busy <= 1'b0;  // Stop bit done.
                tx_line <= 1'b1;
            end else begin
                bit_idx <= bit_idx + 4'd1;
                tx_line <= shift[0];  // LSB first.
            end
        end else if (tx_busy) begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    // Stop bit rides at the top and reaches bit 0 after eight shifts.
    always_ff @(posedge clk) begin
        if (load) begin
            shift <= {1'b1, tx_byte};
        end else if (bit_end) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

    // Software polls status first, so a load never meets a busy frame.
    a_load_idle : assert property (
        @(posedge clk) disable iff (!rst_n) tx_load |-> !tx_busy
    ) else $error("uart_tx: load while busy");

endmodule

/* hdl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx_line,
    input  logic       rx_pop,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;   // First sync flop.
    logic             rx_s;      // Synchronized line.
    logic             rx_prev;   // Last sample for edge detect.
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;   // Data bit being sampled.
    logic [7:0]       shift;
    logic             half_end;  // Middle of the start bit.
    logic             bit_end;   // Middle of a data or stop bit.
    logic             done;      // Good frame.

    assign half_end = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign done     = (state == S_STOP) && bit_end && rx_s;  // Bad stop bit is dropped.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
            rx_prev <= 1'b1;
            state   <= S_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            rx_meta <= rx_line;
            rx_s    <= rx_meta;
            rx_prev <= rx_s;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_s) state <= S_START;  // Falling edge.
                end
                S_START: if (half_end) begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    state   <= rx_s ? S_IDLE : S_DATA;  // Glitch goes back to idle.
                end
                S_DATA: if (bit_end) begin
                    clk_cnt <= '0;
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= S_STOP;
                end
                S_STOP: if (bit_end) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // New byte wins over a pop in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
        end else if (done) begin
            rx_valid <= 1'b1;
        end else if (rx_pop) begin
            rx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == S_DATA) && bit_end) shift <= {rx_s, shift[7:1]};  // LSB arrives first.
        if (done) rx_byte <= shift;  // Overwrites an unread byte.
    end

endmodule

/* hdl/mmio_top.sv */
`timescale 1ns/1ps

module mmio_top #(
    parameter logic [31:0] MMIO_BASE    = 32'h8000_0000,
    parameter int          CLKS_PER_BIT = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mmio_pkg::bus_req_t core_req,
    input  mmio_pkg::bus_req_t dbg_req,
    output mmio_pkg::bus_rsp_t core_rsp,
    output mmio_pkg::bus_rsp_t dbg_rsp,
    output logic               core_gnt,
    output logic               dbg_gnt,
    input  logic               inst_retired,
    input  logic               br_inst,
    input  logic               br_pred,
    output logic               uart_tx_line,
    input  logic               uart_rx_line
);

    mmio_pkg::bus_req_t [mmio_pkg::N_MASTERS-1:0] req_arr;  // Core is master 0.
    mmio_pkg::bus_rsp_t [mmio_pkg::N_MASTERS-1:0] rsp_arr;
    logic               [mmio_pkg::N_MASTERS-1:0] gnt;
    mmio_pkg::bus_req_t sel_req;  // Granted access.
    mmio_pkg::bus_rsp_t sel_rsp;
    logic               tx_load;
    logic [7:0]         tx_byte;
    logic               tx_busy;
    logic               rx_pop;
    logic [7:0]         rx_byte;
    logic               rx_valid;

    assign req_arr  = {dbg_req, core_req};
    assign core_rsp = rsp_arr[0];
    assign dbg_rsp  = rsp_arr[1];
    assign core_gnt = gnt[0];
    assign dbg_gnt  = gnt[1];

    bus_arbiter u_arb (
        .clk(clk), .rst_n(rst_n), .req_in(req_arr), .gnt(gnt),
        .sel_req(sel_req), .sel_rsp(sel_rsp), .rsp_out(rsp_arr)
    );

    io_regs #(.MMIO_BASE(MMIO_BASE)) u_regs (
        .clk(clk), .rst_n(rst_n), .req(sel_req), .rsp(sel_rsp),
        .inst_retired(inst_retired), .br_inst(br_inst), .br_pred(br_pred),
        .tx_load(tx_load), .tx_byte(tx_byte), .tx_busy(tx_busy),
        .rx_pop(rx_pop), .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk(clk), .rst_n(rst_n), .tx_load(tx_load), .tx_byte(tx_byte),
        .tx_busy(tx_busy), .tx_line(uart_tx_line)
    );

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk(clk), .rst_n(rst_n), .rx_line(uart_rx_line), .rx_pop(rx_pop),
        .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // Released away from the active edge.
    end

endmodule

/* verification/mmio_top_tb.sv */
`timescale 1ns/1ps

module mmio_top_tb;

    localparam logic [31:0] BASE      = 32'h8000_0000;
    localparam int          CPB       = 16;  // Clocks per UART bit.
    localparam int          PERIOD_NS = 8;
    localparam int          N_TESTS   = 5;
    localparam int          FRAME_NS  = 10 * CPB * PERIOD_NS;
    localparam int          N_BYTES   = 4;

    // Expected state of the register block.
    typedef struct packed {
        logic [31:0] stamp;     // Clocks since reset, never cleared.
        logic [31:0] cycles;    // Clocks since the last clear.
        logic [31:0] instret;
        logic [31:0] branches;
        logic [31:0] br_hits;
        logic [7:0]  rx_byte;   // Last byte looped back.
        logic        tx_ready;
        logic        rx_valid;
    } model_t;

    logic               clk;
    logic               rst_n;
    mmio_pkg::bus_req_t core_req;
    mmio_pkg::bus_req_t dbg_req;
    mmio_pkg::bus_rsp_t core_rsp;
    mmio_pkg::bus_rsp_t dbg_rsp;
    logic               core_gnt;
    logic               dbg_gnt;
    logic               inst_retired;
    logic               br_inst;
    logic               br_pred;
    wire                uart_line;  // TX pin looped back to RX pin.

    model_t model;
    logic   clear_pending;  // Clear granted, lands on the next edge.
    int     last_gnt;       // Master granted last. Loser gets priority.
    int     value_errs;
    int     other_errs;
    integer seed;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(2)) clk_gen_i (.clk(clk), .rst_n(rst_n));

    mmio_top #(.MMIO_BASE(BASE), .CLKS_PER_BIT(CPB)) mmio_top_i (
        .clk(clk), .rst_n(rst_n), .core_req(core_req), .dbg_req(dbg_req),
        .core_rsp(core_rsp), .dbg_rsp(dbg_rsp), .core_gnt(core_gnt), .dbg_gnt(dbg_gnt),
        .inst_retired(inst_retired), .br_inst(br_inst), .br_pred(br_pred),
        .uart_tx_line(uart_line), .uart_rx_line(uart_line)
    );

    // Counter model. Clear beats a retire in the same cycle.
    always @(posedge clk) begin
        if (rst_n) begin
            model.stamp = model.stamp + 32'd1;
            if (clear_pending) begin
                model.cycles  = 32'h0;
                model.instret = 32'h0;
                clear_pending = 1'b0;
            end else begin
                model.cycles = model.cycles + 32'd1;
                if (inst_retired) model.instret = model.instret + 32'd1;
            end
            if (br_inst) model.branches = model.branches + 32'd1;  // Never cleared.
            if (br_pred) model.br_hits = model.br_hits + 32'd1;
        end
    end

    // Expected read word for an offset.
    function automatic logic [31:0] ref_read(input logic [31:0] off, input model_t m);
        logic [31:0] word;
        word = 32'h0;  // Unmapped and write-only.
        case (off)
            mmio_pkg::REG_UART_STATUS: begin
                word[mmio_pkg::STAT_TX_READY] = m.tx_ready;
                word[mmio_pkg::STAT_RX_VALID] = m.rx_valid;
            end
            mmio_pkg::REG_UART_RX:  word = {24'h0, m.rx_byte};
            mmio_pkg::REG_CYCLES:   word = m.cycles;
            mmio_pkg::REG_INSTRET:  word = m.instret;
            mmio_pkg::REG_BRANCHES: word = m.branches;
            mmio_pkg::REG_BR_HITS:  word = m.br_hits;
            default:                word = 32'h0;
        endcase
        return word;
    endfunction

    function automatic mmio_pkg::bus_rsp_t make_rsp(input logic [31:0] data, input logic valid);
        mmio_pkg::bus_rsp_t r;
        r.rdata = data;
        r.valid = valid;
        return r;
    endfunction

    // Data only matters when a response is due.
    task automatic check_rsp(input string name, input mmio_pkg::bus_rsp_t got,
                             input mmio_pkg::bus_rsp_t exp);
        if (got.valid !== exp.valid) begin
            value_errs++;
            $display("** Error at %0t: %s.valid is %b, expected %b", $time, name,
                     got.valid, exp.valid);
        end else if (exp.valid && (got.rdata !== exp.rdata)) begin
            value_errs++;
            $display("** Error at %0t: %s.rdata is %h, expected %h", $time, name,
                     got.rdata, exp.rdata);
        end
    endtask

    task automatic check_gnt(input logic [mmio_pkg::N_MASTERS-1:0] got,
                             input logic [mmio_pkg::N_MASTERS-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: {dbg_gnt, core_gnt} is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_line(input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0t: uart_tx_line is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic drive_req(input int m, input mmio_pkg::bus_req_t r);
        if (m == 1) dbg_req = r;
        else core_req = r;
    endtask

    // One access from a negedge. Strobe held until the grant.
    task automatic bus_access(input int m, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic we, output mmio_pkg::bus_rsp_t rsp,
                              output model_t snap);
        mmio_pkg::bus_req_t r;
        logic [1:0]         want;
        r.addr  = addr;
        r.wdata = wdata;
        r.we    = we;
        r.req   = 1'b1;
        want    = (m == 1) ? 2'b10 : 2'b01;
        drive_req(m, r);
        #1;
        while (({dbg_gnt, core_gnt} & want) == 2'b00) begin
            @(negedge clk);
            #1;
        end
        check_gnt({dbg_gnt, core_gnt}, want);
        snap     = model;  // State seen at the grant edge.
        last_gnt = m;
        if (we && ((addr - BASE) == mmio_pkg::REG_CLEAR)) clear_pending = 1'b1;
        @(negedge clk);
        r.req = 1'b0;
        drive_req(m, r);
        rsp = (m == 1) ? dbg_rsp : core_rsp;
        if (we) check_rsp((m == 1) ? "dbg_rsp" : "core_rsp", rsp, make_rsp(32'h0, 1'b0));
    endtask

    task automatic read_check(input int m, input logic [31:0] off,
                              output mmio_pkg::bus_rsp_t rsp, output model_t snap);
        bus_access(m, BASE + off, 32'h0, 1'b0, rsp, snap);
        check_rsp((m == 1) ? "dbg_rsp" : "core_rsp", rsp, make_rsp(ref_read(off, snap), 1'b1));
    endtask

    task automatic write_reg(input int m, input logic [31:0] off, input logic [31:0] data);
        mmio_pkg::bus_rsp_t rsp;
        model_t             snap;
        bus_access(m, BASE + off, data, 1'b1, rsp, snap);
    endtask

    // Status reads until the bit is set. Watchdog bounds the wait.
    task automatic poll_status(input int bit_idx);
        mmio_pkg::bus_rsp_t rsp;
        model_t             snap;
        do begin
            bus_access(0, BASE + mmio_pkg::REG_UART_STATUS, 32'h0, 1'b0, rsp, snap);
        end while (!(rsp.valid && rsp.rdata[bit_idx]));
    endtask

    task automatic drive_events(input int n_cycles);
        logic [31:0] rnd;
        repeat (n_cycles) begin
            rnd          = $random(seed);
            inst_retired = rnd[0];
            br_inst      = rnd[1];
            br_pred      = rnd[1] & rnd[2];  // Hits only on branches.
            @(negedge clk);
        end
        inst_retired = 1'b0;
        br_inst      = 1'b0;
        br_pred      = 1'b0;
    endtask

    // Both masters read every cycle. Grants alternate, replies follow by one cycle.
    task automatic arbitration_test(input int n_cycles);
        logic [1:0] cur;
        logic [1:0] exp_g;
        logic [1:0] prev;
        prev = 2'b00;
        @(negedge clk);  // One idle cycle so no reply is pending.
        core_req = '{addr: BASE + mmio_pkg::REG_BRANCHES, wdata: 32'h0, we: 1'b0, req: 1'b1};
        dbg_req  = '{addr: BASE + mmio_pkg::REG_BR_HITS, wdata: 32'h0, we: 1'b0, req: 1'b1};
        for (int i = 0; i <= n_cycles; i++) begin
            if (i == n_cycles) begin
                core_req.req = 1'b0;
                dbg_req.req  = 1'b0;
            end
            #1;
            cur   = {dbg_gnt, core_gnt};
            exp_g = (i == n_cycles) ? 2'b00 : ((last_gnt == 1) ? 2'b01 : 2'b10);
            check_gnt(cur, exp_g);
            check_rsp("core_rsp", core_rsp,
                      make_rsp(ref_read(mmio_pkg::REG_BRANCHES, model), prev[0]));
            check_rsp("dbg_rsp", dbg_rsp,
                      make_rsp(ref_read(mmio_pkg::REG_BR_HITS, model), prev[1]));
            if (exp_g != 2'b00) last_gnt = exp_g[1] ? 1 : 0;
            prev = exp_g;
            @(negedge clk);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if ((value_errs + other_errs) == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        #(N_TESTS * 12 * FRAME_NS);
        other_errs++;
        $display("Watchdog expired after %0d ns, the tests did not finish", N_TESTS * 12 * FRAME_NS);
        finish_run();
    end

    initial begin : main
        mmio_pkg::bus_rsp_t r1;
        mmio_pkg::bus_rsp_t r2;
        model_t             s1;
        model_t             s2;
        logic [31:0]        rnd;
        core_req       = '0;
        dbg_req        = '0;
        inst_retired   = 1'b0;
        br_inst        = 1'b0;
        br_pred        = 1'b0;
        model          = '0;
        model.tx_ready = 1'b1;
        clear_pending  = 1'b0;
        last_gnt       = 1;  // Core has priority out of reset.
        value_errs     = 0;
        other_errs     = 0;
        seed           = 79461;
        @(posedge rst_n);
        @(negedge clk);

        // Idle state out of reset.
        check_gnt({dbg_gnt, core_gnt}, 2'b00);
        check_rsp("core_rsp", core_rsp, make_rsp(32'h0, 1'b0));
        check_rsp("dbg_rsp", dbg_rsp, make_rsp(32'h0, 1'b0));
        check_line(uart_line, 1'b1);  // Idle line is high.

        // Event counters.
        drive_events(200);
        read_check(0, mmio_pkg::REG_INSTRET, r1, s1);
        read_check(0, mmio_pkg::REG_BRANCHES, r1, s1);
        read_check(1, mmio_pkg::REG_BR_HITS, r1, s1);

        // Cycle counter delta, then clear.
        read_check(0, mmio_pkg::REG_CYCLES, r1, s1);
        rnd = $random(seed);
        repeat (rnd[3:0] + 1) @(negedge clk);
        read_check(1, mmio_pkg::REG_CYCLES, r2, s2);
        if ((r2.rdata - r1.rdata) !== (s2.stamp - s1.stamp)) begin
            value_errs++;
            $display("** Error at %0t: cycle delta is %0d, expected %0d", $time,
                     r2.rdata - r1.rdata, s2.stamp - s1.stamp);
        end
        write_reg(1, mmio_pkg::REG_CLEAR, 32'h0);
        drive_events(20);
        read_check(0, mmio_pkg::REG_CYCLES, r1, s1);
        read_check(0, mmio_pkg::REG_INSTRET, r1, s1);
        read_check(1, mmio_pkg::REG_BRANCHES, r1, s1);  // Kept across the clear.
        read_check(1, mmio_pkg::REG_BR_HITS, r1, s1);

        // UART loopback.
        read_check(0, mmio_pkg::REG_UART_STATUS, r1, s1);
        for (int i = 0; i < N_BYTES; i++) begin
            rnd = $random(seed);
            poll_status(mmio_pkg::STAT_TX_READY);
            write_reg(0, mmio_pkg::REG_UART_TX, {24'h0, rnd[7:0]});
            model.rx_byte = rnd[7:0];
            check_line(uart_line, 1'b1);  // Load pulse is in this cycle.
            @(negedge clk);
            check_line(uart_line, 1'b0);  // Start bit one cycle after the load.
            poll_status(mmio_pkg::STAT_RX_VALID);
            model.rx_valid = 1'b1;
            read_check(0, mmio_pkg::REG_UART_RX, r1, s1);
            model.rx_valid = 1'b0;  // Popped by the read.
            poll_status(mmio_pkg::STAT_TX_READY);
            read_check(0, mmio_pkg::REG_UART_STATUS, r1, s1);
        end

        // Arbitration under full load.
        arbitration_test(16);

        // Unmapped addresses, above the map and below the base.
        read_check(0, 32'h0000_0040, r1, s1);
        read_check(1, 32'hFFFF_FFFC, r1, s1);

        finish_run();
    end

endmodule

/* files.f */
hdl/mmio_pkg.sv
hdl/bus_arbiter.sv
hdl/io_regs.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/mmio_top.sv
verification/tb_clock_gen.sv
verification/mmio_top_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mmio_top_tb
FILELIST = files.f
OBJDIR   = obj_dir
PASS_MSG = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
